// ==== verilog.f ====
source/serial_bus_pkg.sv
source/slave_cmd_if.sv
source/control_deserializer.sv
source/slave_word_engine.sv
source/serial_slave.sv
source/bus_response_merge.sv
source/serial_bus_node.sv
verification/serial_bus_assertions.sv
verification/serial_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the serial bus node testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_serial_bus_node -o sim_serial_bus
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_serial_bus)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/serial_bus_tb.sv ====
/* serial bus node testbench
   frame and word driver, reference memory per slave, serial read checker */
`timescale 1ns/100ps

module tb_serial_bus_node;

    localparam int ADDR_DEPTH = 256;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = $clog2(ADDR_DEPTH);
    localparam int FRAME_LEN  = 3 + serial_bus_pkg::S_ID_WIDTH + 2 + ADDR_WIDTH;
    localparam int TIMEOUT    = 400;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;
    logic busy;

    logic [31:0]           lfsr_state = 32'ha03d;
    logic [DATA_WIDTH-1:0] mem_s1 [int];
    logic [DATA_WIDTH-1:0] mem_s2 [int];
    logic [DATA_WIDTH-1:0] sent_words [$];
    int                    errors = 0;
    int                    checks = 0;
    // read checker state
    logic                  collect = 1'b0;
    int                    rd_id = 0;
    int                    rd_addr = 0;
    logic [DATA_WIDTH-1:0] rx_word = '0;
    int                    rx_bits = 0;
    int                    words_seen = 0;
    int                    words_checked = 0;
    int                    rd_errors = 0;

    serial_bus_node #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_serial_bus_node (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_word(input int id, input int addr);
        if (id == 1 && mem_s1.exists(addr)) begin
            return mem_s1[addr];
        end
        if (id == 2 && mem_s2.exists(addr)) begin
            return mem_s2[addr];
        end
        return 'x;
    endfunction

    // rD bits count while the selected slave presents data
    always @(negedge clk) begin
        if (collect && busy && ready) begin
            rx_word = {rx_word[DATA_WIDTH-2:0], rD};
            rx_bits++;
            if (rx_bits == DATA_WIDTH) begin
                words_checked++;
                assert (rx_word === expected_word(rd_id, (rd_addr + words_seen) % ADDR_DEPTH))
                else begin
                    $display("MISMATCH rD word (slave %0d addr %h): got %h expected %h", rd_id,
                             (rd_addr + words_seen) % ADDR_DEPTH, rx_word,
                             expected_word(rd_id, (rd_addr + words_seen) % ADDR_DEPTH));
                    rd_errors++;
                end
                words_seen++;
                rx_bits = 0;
            end
        end
    end

    task automatic send_frame(input serial_bus_pkg::start_code_t start, input int id,
                              input logic is_write, input logic is_burst, input int addr);
        logic [FRAME_LEN-1:0] frame;
        frame = {start, serial_bus_pkg::slave_id_t'(id), is_write, is_burst, ADDR_WIDTH'(addr)};
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            @(negedge clk);
            control = frame[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    task automatic write_words(input int n_words, input bit with_gaps);
        logic [DATA_WIDTH-1:0] word;
        sent_words.delete();
        for (int w = 0; w < n_words; w++) begin
            word = random_bits(DATA_WIDTH);
            sent_words.push_back(word);
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                if (with_gaps && random_bits(1) != 32'd0) begin
                    @(negedge clk);
                    valid = 1'b0;
                end
                @(negedge clk);
                valid = 1'b1;
                wD    = word[b];
                last  = (w == n_words - 1) && (b == 0);
            end
            // engine stores the word in this cycle
            @(negedge clk);
            valid = 1'b0;
            last  = 1'b0;
        end
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (busy === level) else begin
            $display("timeout waiting for busy to become %0d during %s", level, what);
            errors++;
        end
    endtask

    task automatic wait_words(input int n_words);
        int cycles;
        cycles = 0;
        while (words_seen < n_words && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (words_seen >= n_words) else begin
            $display("timeout waiting for %0d read words, saw %0d", n_words, words_seen);
            errors++;
        end
    endtask

    task automatic write_transfer(input int id, input int addr, input int n_words,
                                  input logic is_burst, input bit with_gaps);
        send_frame(serial_bus_pkg::START_CODE, id, 1'b1, is_burst, addr);
        wait_busy(1'b1, "write start");
        write_words(n_words, with_gaps);
        for (int i = 0; i < n_words; i++) begin
            if (id == 1) begin
                mem_s1[(addr + i) % ADDR_DEPTH] = sent_words[i];
            end else begin
                mem_s2[(addr + i) % ADDR_DEPTH] = sent_words[i];
            end
        end
        wait_busy(1'b0, "write end");
    endtask

    task automatic read_transfer(input int id, input int addr, input int n_words,
                                 input logic is_burst);
        rd_id      = id;
        rd_addr    = addr;
        rx_bits    = 0;
        words_seen = 0;
        collect    = 1'b1;
        send_frame(serial_bus_pkg::START_CODE, id, 1'b0, is_burst, addr);
        wait_busy(1'b1, "read start");
        if (is_burst) begin
            // last is only sampled on a word's final bit
            wait_words(n_words - 1);
            last = 1'b1;
        end
        wait_busy(1'b0, "read end");
        last = 1'b0;
        checks++;
        assert (words_seen == n_words) else begin
            $display("read from slave %0d returned %0d words instead of %0d", id, words_seen,
                     n_words);
            errors++;
        end
        collect = 1'b0;
    endtask

    task automatic check_idle(input int n_cycles);
        repeat (n_cycles) begin
            @(negedge clk);
            checks++;
            assert (busy === 1'b0) else begin
                $display("MISMATCH busy: got %h expected %h", busy, 1'b0);
                errors++;
            end
            assert (ready === 1'b1) else begin
                $display("MISMATCH ready: got %h expected %h", ready, 1'b1);
                errors++;
            end
        end
    endtask

    initial begin
        int a1;
        int a2;
        int a4;
        int a5;
        rstN    = 1'b0;
        control = 1'b0;
        wD      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        checks++;
        assert (rD === 1'b0) else begin
            $display("MISMATCH rD: got %h expected %h", rD, 1'b0);
            errors++;
        end
        check_idle(2);

        a1 = int'(random_bits(ADDR_WIDTH));
        a2 = int'(random_bits(ADDR_WIDTH));
        a4 = int'(random_bits(ADDR_WIDTH));
        a5 = int'(random_bits(ADDR_WIDTH));

        // single write and read on slave 1
        write_transfer(1, a1, 1, 1'b0, 1'b0);
        read_transfer(1, a1, 1, 1'b0);

        // four word burst
        write_transfer(1, a2, 4, 1'b1, 1'b1);
        read_transfer(1, a2, 4, 1'b1);

        // unknown slave ID, then a bad start code
        send_frame(serial_bus_pkg::START_CODE, 3, 1'b1, 1'b0, a1);
        check_idle(4);
        write_words(1, 1'b0);
        check_idle(4);
        send_frame(3'b101, 1, 1'b1, 1'b0, a1);
        check_idle(4);
        write_words(1, 1'b0);
        check_idle(4);
        read_transfer(1, a1, 1, 1'b0);

        // both slaves at one address
        write_transfer(1, a4, 1, 1'b0, 1'b0);
        write_transfer(2, a4, 1, 1'b0, 1'b0);
        read_transfer(1, a4, 1, 1'b0);
        read_transfer(2, a4, 1, 1'b0);

        // valid gaps inside the word
        write_transfer(2, a5, 1, 1'b0, 1'b1);
        read_transfer(2, a5, 1, 1'b0);

        repeat (2) @(negedge clk);
        $display("summary: %0d words compared, %0d checks, %0d errors", words_checked, checks,
                 errors + rd_errors);
        if (errors + rd_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/serial_bus_assertions.sv ====
/* serial bus node bus checks
   concurrent checks on the registered bus response outputs */
`timescale 1ns/100ps

module serial_bus_assertions (
    input logic clk,
    input logic rstN,
    input logic rD,
    input logic ready,
    input logic busy
);

    // idle bus shows the default response
    assert property (@(posedge clk) disable iff (!rstN) !busy |-> ready)
        else $error("ready low while the bus is idle");

    assert property (@(posedge clk) disable iff (!rstN) !busy |-> !rD)
        else $error("rD high while the bus is idle");

    // a transfer never holds busy for a single cycle only
    assert property (@(posedge clk) disable iff (!rstN) $fell(busy) |-> $past(busy, 2))
        else $error("busy was high for only one cycle");

endmodule

bind serial_bus_node serial_bus_assertions i_serial_bus_assertions (
    .clk   (clk),
    .rstN  (rstN),
    .rD    (rD),
    .ready (ready),
    .busy  (busy)
);

// ==== source/serial_bus_node.sv ====
/* serial bus endpoint node
   two memory slaves on one serial bus with a merged registered response */
`timescale 1ns/100ps

module serial_bus_node #(
    parameter int ADDR_DEPTH = 256,
    parameter int DATA_WIDTH = 32
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready,
    output logic busy
);

    logic rd_1;
    logic ready_1;
    logic active_1;
    logic rd_2;
    logic ready_2;
    logic active_2;

    // both slaves listen to the same control, wD, valid and last
    serial_slave #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SLAVE_ID   (1)
    ) i_slave_1 (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rd      (rd_1),
        .ready   (ready_1),
        .active  (active_1)
    );

    serial_slave #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SLAVE_ID   (2)
    ) i_slave_2 (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rd      (rd_2),
        .ready   (ready_2),
        .active  (active_2)
    );

    bus_response_merge i_bus_response_merge (
        .clk      (clk),
        .rstN     (rstN),
        .rd_a     (rd_1),
        .ready_a  (ready_1),
        .active_a (active_1),
        .rd_b     (rd_2),
        .ready_b  (ready_2),
        .active_b (active_2),
        .rD       (rD),
        .ready    (ready),
        .busy     (busy)
    );

endmodule

// ==== source/bus_response_merge.sv ====
/* bus response merger
   selects the active slave's response and registers it onto the bus */
`timescale 1ns/100ps

module bus_response_merge (
    input  logic clk,
    input  logic rstN,
    input  logic rd_a,
    input  logic ready_a,
    input  logic active_a,
    input  logic rd_b,
    input  logic ready_b,
    input  logic active_b,
    output logic rD,
    output logic ready,
    output logic busy
);

    logic rd_sel;
    logic ready_sel;

    // at most one slave is active at a time
    always_comb begin
        if (active_a) begin
            rd_sel    = rd_a;
            ready_sel = ready_a;
        end else if (active_b) begin
            rd_sel    = rd_b;
            ready_sel = ready_b;
        end else begin
            rd_sel    = 1'b0;
            ready_sel = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rD    <= 1'b0;
            ready <= 1'b1;
            busy  <= 1'b0;
        end else begin
            rD    <= rd_sel;
            ready <= ready_sel;
            busy  <= active_a || active_b;
        end
    end

endmodule

// ==== source/serial_slave.sv ====
/* serial bus slave
   one addressable slave, frame deserializer feeding the word engine */
`timescale 1ns/100ps

module serial_slave #(
    parameter int ADDR_DEPTH = 256,
    parameter int DATA_WIDTH = 32,
    parameter int SLAVE_ID   = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready,
    output logic active
);

    slave_cmd_if #(.ADDR_WIDTH($clog2(ADDR_DEPTH))) cmd_bus ();

    control_deserializer #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .SLAVE_ID   (SLAVE_ID)
    ) i_control_deserializer (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .cmd     (cmd_bus.decoder)
    );

    slave_word_engine #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_slave_word_engine (
        .clk    (clk),
        .rstN   (rstN),
        .wD     (wD),
        .valid  (valid),
        .last   (last),
        .cmd    (cmd_bus.engine),
        .rd     (rd),
        .ready  (ready),
        .active (active)
    );

endmodule

// ==== source/slave_word_engine.sv ====
/* slave word engine
   slave memory with serial word write and read, burst address stepping */
`timescale 1ns/100ps

module slave_word_engine #(
    parameter int ADDR_DEPTH = 256,
    parameter int DATA_WIDTH = 32
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wD,
    input  logic        valid,
    input  logic        last,
    slave_cmd_if.engine cmd,
    output logic        rd,
    output logic        ready,
    output logic        active
);

    localparam int ADDR_WIDTH = $clog2(ADDR_DEPTH);
    localparam int CNT_WIDTH  = $clog2(DATA_WIDTH);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [CNT_WIDTH-1:0]  bit_cnt_t;

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(DATA_WIDTH - 1);

    serial_bus_pkg::engine_state_t state;
    addr_t                         addr_q;
    bit_cnt_t                      bit_cnt;
    logic                          burst_q;
    logic                          last_q;
    word_t                         mem [ADDR_DEPTH];
    word_t                         wr_buf;
    word_t                         rd_buf;
    logic                          wr_shift;
    logic                          word_done;

    assign wr_shift  = (state == serial_bus_pkg::EN_WRITE) && valid;
    assign word_done = (bit_cnt == LAST_BIT);

    // transfer sequencing
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= serial_bus_pkg::EN_IDLE;
            addr_q  <= '0;
            bit_cnt <= '0;
            burst_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            case (state)
                serial_bus_pkg::EN_IDLE: begin
                    if (cmd.cmd_strobe) begin
                        addr_q  <= cmd.start_addr;
                        burst_q <= cmd.is_burst;
                        bit_cnt <= '0;
                        state   <= cmd.is_write ? serial_bus_pkg::EN_WRITE
                                                : serial_bus_pkg::EN_LOAD;
                    end
                end
                serial_bus_pkg::EN_WRITE: begin
                    // valid low simply holds the count
                    if (wr_shift) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (word_done) begin
                            bit_cnt <= '0;
                            last_q  <= last;
                            state   <= serial_bus_pkg::EN_STORE;
                        end
                    end
                end
                serial_bus_pkg::EN_STORE: begin
                    if (!burst_q || last_q) begin
                        state <= serial_bus_pkg::EN_IDLE;
                    end else begin
                        addr_q <= addr_q + 1'b1;
                        state  <= serial_bus_pkg::EN_WRITE;
                    end
                end
                serial_bus_pkg::EN_LOAD: begin
                    bit_cnt <= '0;
                    state   <= serial_bus_pkg::EN_READ;
                end
                serial_bus_pkg::EN_READ: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (word_done) begin
                        bit_cnt <= '0;
                        // last sampled with the final bit of the word
                        if (!burst_q || last) begin
                            state <= serial_bus_pkg::EN_IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                            state  <= serial_bus_pkg::EN_LOAD;
                        end
                    end
                end
                default: state <= serial_bus_pkg::EN_IDLE;
            endcase
        end
    end

    // memory and shift buffers
    always_ff @(posedge clk) begin
        if (state == serial_bus_pkg::EN_STORE) begin
            mem[addr_q] <= wr_buf;
        end
        if (wr_shift) begin
            wr_buf <= {wr_buf[DATA_WIDTH-2:0], wD};
        end
        if (state == serial_bus_pkg::EN_LOAD) begin
            rd_buf <= mem[addr_q];
        end else if (state == serial_bus_pkg::EN_READ) begin
            rd_buf <= {rd_buf[DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign active   = (state != serial_bus_pkg::EN_IDLE);
    assign cmd.busy = active;

    // low only while the memory is accessed
    assign ready = (state == serial_bus_pkg::EN_IDLE)  ||
                   (state == serial_bus_pkg::EN_WRITE) ||
                   (state == serial_bus_pkg::EN_READ);

    assign rd = (state == serial_bus_pkg::EN_READ) && rd_buf[DATA_WIDTH-1];

endmodule

// ==== source/control_deserializer.sv ====
/* control frame deserializer
   collects a serial control frame, checks start code and slave ID, issues a command */
`timescale 1ns/100ps

module control_deserializer #(
    parameter int ADDR_DEPTH = 256,
    parameter int SLAVE_ID   = 1
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            control,
    slave_cmd_if.decoder    cmd
);

    localparam int ADDR_WIDTH = $clog2(ADDR_DEPTH);
    localparam int FRAME_LEN  = 3 + serial_bus_pkg::S_ID_WIDTH + 2 + ADDR_WIDTH;
    localparam int CNT_WIDTH  = $clog2(FRAME_LEN + 1);

    // field positions, first bit received ends up at the msb
    localparam int ID_MSB    = FRAME_LEN - 4;
    localparam int RW_BIT    = ADDR_WIDTH + 1;
    localparam int BURST_BIT = ADDR_WIDTH;

    localparam logic [CNT_WIDTH-1:0] FINAL_BIT = CNT_WIDTH'(FRAME_LEN - 1);

    serial_bus_pkg::frame_state_t state;
    logic [CNT_WIDTH-1:0]         bit_cnt;
    logic [FRAME_LEN-1:0]         frame_q;
    serial_bus_pkg::start_code_t  start_f;
    serial_bus_pkg::slave_id_t    id_f;
    logic                         frame_ok;

    // frame bit counter and state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= serial_bus_pkg::FR_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                serial_bus_pkg::FR_IDLE: begin
                    // first high bit opens a frame, only while the engine is free
                    if (control && !cmd.busy) begin
                        bit_cnt <= CNT_WIDTH'(1);
                        state   <= serial_bus_pkg::FR_SHIFT;
                    end
                end
                serial_bus_pkg::FR_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == FINAL_BIT) begin
                        state <= serial_bus_pkg::FR_CHECK;
                    end
                end
                serial_bus_pkg::FR_CHECK: begin
                    bit_cnt <= '0;
                    state   <= serial_bus_pkg::FR_IDLE;
                end
                default: state <= serial_bus_pkg::FR_IDLE;
            endcase
        end
    end

    // frame bits, msb first
    always_ff @(posedge clk) begin
        if ((state == serial_bus_pkg::FR_SHIFT) ||
            (state == serial_bus_pkg::FR_IDLE && control && !cmd.busy)) begin
            frame_q <= {frame_q[FRAME_LEN-2:0], control};
        end
    end

    assign start_f  = frame_q[FRAME_LEN-1 -: 3];
    assign id_f     = frame_q[ID_MSB -: serial_bus_pkg::S_ID_WIDTH];
    assign frame_ok = (start_f == serial_bus_pkg::START_CODE) &&
                      (id_f == serial_bus_pkg::slave_id_t'(SLAVE_ID));

    // frames for other slaves are dropped here
    assign cmd.cmd_strobe = (state == serial_bus_pkg::FR_CHECK) && frame_ok && !cmd.busy;
    assign cmd.is_write   = frame_q[RW_BIT];
    assign cmd.is_burst   = frame_q[BURST_BIT];
    assign cmd.start_addr = frame_q[ADDR_WIDTH-1:0];

endmodule

// ==== source/slave_cmd_if.sv ====
/* decoded slave command
   carries one frame's command from the frame decoder to the word engine */
`timescale 1ns/100ps

interface slave_cmd_if #(
    parameter int ADDR_WIDTH = 8
);

    logic                  cmd_strobe;
    logic                  is_write;
    logic                  is_burst;
    logic [ADDR_WIDTH-1:0] start_addr;
    // high while the engine runs a transfer
    logic                  busy;

    modport decoder (
        output cmd_strobe, is_write, is_burst, start_addr,
        input  busy
    );

    modport engine (
        input  cmd_strobe, is_write, is_burst, start_addr,
        output busy
    );

endinterface

// ==== source/serial_bus_pkg.sv ====
/* serial bus shared definitions
   frame constants, field types and state encodings for the endpoint node */
package serial_bus_pkg;

    // frame start pattern and slave ID width
    localparam logic [2:0] START_CODE = 3'b111;
    localparam int         S_ID_WIDTH = 2;

    typedef logic [S_ID_WIDTH-1:0] slave_id_t;
    typedef logic [2:0]            start_code_t;

    // control frame receiver
    typedef enum logic [1:0] {
        FR_IDLE,
        FR_SHIFT,
        FR_CHECK
    } frame_state_t;

    // word transfer engine
    typedef enum logic [2:0] {
        EN_IDLE,
        EN_WRITE,
        EN_STORE,
        EN_LOAD,
        EN_READ
    } engine_state_t;

endpackage
